/* hw/usiPkg.sv */
// Shared definitions for the USI register bus subsystem
// Address and data widths, block map, CSR offsets and the address view
// Modules import this package inside their body and use scoped names in headers
package usiPkg;

	// --------------------
	// Bus widths
	// --------------------
	localparam int usiAdrsWidth  = 24;
	localparam int usiDataWidth  = 32;
	localparam int usiBlockWidth = 8;
	localparam int usiOffWidth   = 16;

	// Slave blocks on the fabric, also the read-enable vector width
	localparam int usiBlocks = 2;

	// --------------------
	// Block map
	// --------------------
	localparam logic [usiBlockWidth-1:0] csrBlockId  = 8'h01;
	// Slot k answers block scratchBase + k
	localparam logic [usiBlockWidth-1:0] scratchBase = 8'h02;

	// Master CSR status offsets
	localparam logic [usiOffWidth-1:0] csrOffLastWd   = 16'h0000;
	localparam logic [usiOffWidth-1:0] csrOffLastAdrs = 16'h0004;
	localparam logic [usiOffWidth-1:0] csrOffWrCount  = 16'h0008;
	localparam logic [usiOffWidth-1:0] csrOffBusRd    = 16'h000C;
	localparam logic [usiOffWidth-1:0] csrOffREd      = 16'h0010;

	// Scratch block id register
	localparam logic [usiOffWidth-1:0] scratchOffId = 16'h0010;

	// AR handshake to RVALID, in cycles
	localparam int readLatency = 5;

	// AXI response code, always OKAY here
	localparam logic [1:0] axiRespOkay = 2'b00;

	// Block field above the offset field
	typedef struct packed {
		logic [usiBlockWidth-1:0] block;
		logic [usiOffWidth-1:0]   offset;
	} usiAdrsFieldsT;

	// Raw address or decoded fields of the same word
	typedef union packed {
		logic [usiAdrsWidth-1:0] raw;
		usiAdrsFieldsT           f;
	} usiAdrsT;

endpackage

/* hw/usiBusIf.sv */
// One USI link between a bus master and a slave
// Master drives the write command, slave answers with read data and its enable bit
// Instance one per link and connect through the master or slave modport
interface usiBusIf;
	import usiPkg::*;

	// Write command, registered by the master
	logic [usiDataWidth-1:0] wd;
	usiAdrsT                 adrs;
	// One cycle pulse per write
	logic                    wEd;

	// Read return, present for the current address
	logic [usiDataWidth-1:0] rd;
	// One bit per slave block
	logic [usiBlocks-1:0]    rEd;

	modport master (
		output wd, adrs, wEd,
		input  rd, rEd
	);

	modport slave (
		input  wd, adrs, wEd,
		output rd, rEd
	);

endinterface

/* hw/axiLiteCsrBridge.sv */
// AXI4-Lite slave that feeds the manual CSR port of the master CSR
// One transaction at a time, writes win over reads in the same idle cycle
// A write gives one wCke pulse, a read waits a fixed readLatency before RVALID
module axiLiteCsrBridge (
	input  logic                             iSCLK,
	input  logic                             iSRST,
	// AXI4-Lite slave
	input  logic [usiPkg::usiAdrsWidth-1:0]  awaddr,
	input  logic                             awvalid,
	output logic                             awready,
	input  logic [usiPkg::usiDataWidth-1:0]  wdata,
	input  logic                             wvalid,
	output logic                             wready,
	output logic [1:0]                       bresp,
	output logic                             bvalid,
	input  logic                             bready,
	input  logic [usiPkg::usiAdrsWidth-1:0]  araddr,
	input  logic                             arvalid,
	output logic                             arready,
	output logic [usiPkg::usiDataWidth-1:0]  rdata,
	output logic [1:0]                       rresp,
	output logic                             rvalid,
	input  logic                             rready,
	// Manual CSR port
	output logic [usiPkg::usiDataWidth-1:0]  wd,
	output usiPkg::usiAdrsT                  adrs,
	output logic                             wCke,
	input  logic [usiPkg::usiDataWidth-1:0]  rd
);
	import usiPkg::*;

	typedef enum logic [2:0] {
		stIdle,
		stWrCollect,
		stWrResp,
		stRdCount,
		stRdResp
	} stateT;

	localparam int cntWidth = $clog2(readLatency);

	stateT                   state;
	stateT                   nextState;
	// High while new AW, W or AR may be taken
	logic                    openQ;
	logic                    awHeld;
	logic                    wHeld;
	logic                    wCkeQ;
	logic                    bvalidQ;
	logic                    rvalidQ;
	logic [cntWidth-1:0]     rdCnt;
	usiAdrsT                 adrsQ;
	logic [usiDataWidth-1:0] wdQ;
	logic                    awFire;
	logic                    wFire;
	logic                    arFire;
	logic                    awDone;
	logic                    wDone;
	logic                    rdLast;

	// --------------------
	// Handshakes
	// --------------------
	assign awready = openQ && !awHeld;
	assign wready  = openQ && !wHeld;
	// Pending write channels keep AR waiting
	assign arready = openQ && (state == stIdle) && !awvalid && !wvalid;

	assign awFire = awvalid && awready;
	assign wFire  = wvalid && wready;
	assign arFire = arvalid && arready;

	// Channel taken earlier or in this cycle
	assign awDone = awHeld || awFire;
	assign wDone  = wHeld || wFire;

	// Final count cycle of a read
	assign rdLast = (state == stRdCount) && (rdCnt == '0);

	// --------------------
	// FSM
	// --------------------
	always_comb
	begin
		nextState = state;
		case (state)
			stIdle, stWrCollect:
			begin
				if (awDone && wDone)
					nextState = stWrResp;
				else if (awDone || wDone)
					nextState = stWrCollect;
				else if (arFire)
					nextState = stRdCount;
			end
			stWrResp:
			begin
				if (bvalidQ && bready)
					nextState = stIdle;
			end
			stRdCount:
			begin
				if (rdLast)
					nextState = stRdResp;
			end
			stRdResp:
			begin
				if (rvalidQ && rready)
					nextState = stIdle;
			end
			default:
				nextState = stIdle;
		endcase
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state   <= stIdle;
			openQ   <= 1'b0;
			awHeld  <= 1'b0;
			wHeld   <= 1'b0;
			wCkeQ   <= 1'b0;
			bvalidQ <= 1'b0;
			rvalidQ <= 1'b0;
			rdCnt   <= '0;
			adrsQ   <= '0;
			wdQ     <= '0;
		end
		else
		begin
			state <= nextState;
			openQ <= (nextState == stIdle) || (nextState == stWrCollect);
			// Held flags drop once both channels are in
			awHeld <= awDone && !wDone;
			wHeld  <= wDone && !awDone;
			// Single strobe toward the CSR
			wCkeQ <= awDone && wDone;
			// Response rises with the CSR's bus strobe
			bvalidQ <= wCkeQ || (bvalidQ && !bready);
			rvalidQ <= rdLast || (rvalidQ && !rready);
			// Count ends one cycle before RVALID
			if (arFire)
				rdCnt <= cntWidth'(readLatency - 2);
			else if ((state == stRdCount) && (rdCnt != '0))
				rdCnt <= rdCnt - 1'b1;
			// AW and AR never fire together
			if (awFire)
				adrsQ.raw <= awaddr;
			else if (arFire)
				adrsQ.raw <= araddr;
			if (wFire)
				wdQ <= wdata;
		end
	end

	assign bresp  = axiRespOkay;
	assign bvalid = bvalidQ;
	assign rresp  = axiRespOkay;
	assign rvalid = rvalidQ;
	// CSR output register settles as RVALID rises, held while adrs holds
	assign rdata  = rd;
	assign wd     = wdQ;
	assign adrs   = adrsQ;
	assign wCke   = wCkeQ;

endmodule

/* hw/microControllerCsr.sv */
// Master control and status registers of the USI bus
// The manual port (wd, adrs, wCke) is registered onto the bus every cycle
// rd always shows the value for the current address, no handshake
// Block csrBlockId returns the status registers, any other block the bus data
module microControllerCsr (
	input  logic                            iSCLK,
	input  logic                            iSRST,
	input  logic [usiPkg::usiDataWidth-1:0] wd,
	input  usiPkg::usiAdrsT                 adrs,
	input  logic                            wCke,
	output logic [usiPkg::usiDataWidth-1:0] rd,
	usiBusIf.master                         bus
);
	import usiPkg::*;

	// Status registers
	logic [usiDataWidth-1:0] lastWd;
	usiAdrsT                 lastAdrs;
	logic [usiDataWidth-1:0] wrCount;
	logic [usiDataWidth-1:0] lastBusRd;
	logic [usiBlocks-1:0]    lastREd;
	// Bus read word, one stage behind the slaves
	logic [usiDataWidth-1:0] busRdQ;

	// --------------------
	// Bus command and capture
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			bus.wd    <= '0;
			bus.adrs  <= '0;
			bus.wEd   <= 1'b0;
			busRdQ    <= '0;
			lastWd    <= '0;
			lastAdrs  <= '0;
			wrCount   <= '0;
			lastBusRd <= '0;
			lastREd   <= '0;
		end
		else
		begin
			// Registered strobe becomes the wEd pulse
			bus.wd   <= wd;
			bus.adrs <= adrs;
			bus.wEd  <= wCke;
			// No answering block reads as zero
			busRdQ <= (|bus.rEd) ? bus.rd : '0;
			// Write history
			if (wCke)
			begin
				lastWd   <= wd;
				lastAdrs <= adrs;
				wrCount  <= wrCount + 1'b1;
			end
			// Keep last answer from a mapped block
			if (|bus.rEd)
			begin
				lastBusRd <= bus.rd;
				lastREd   <= bus.rEd;
			end
		end
	end

	// --------------------
	// Processor read
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			rd <= '0;
		else if (adrs.f.block == csrBlockId)
		begin
			case (adrs.f.offset)
				csrOffLastWd:   rd <= lastWd;
				csrOffLastAdrs: rd <= usiDataWidth'(lastAdrs.raw);
				csrOffWrCount:  rd <= wrCount;
				csrOffBusRd:    rd <= lastBusRd;
				csrOffREd:      rd <= usiDataWidth'(lastREd);
				default:        rd <= '0;
			endcase
		end
		else
			rd <= busRdQ;
	end

endmodule

/* hw/usiBusFabric.sv */
// Fabric between the master CSR and the slave blocks
// Broadcasts data and address, gates wEd by the block field of the address
// Merges slave read data by their read-enable bits, unmapped blocks read zero
// Slot k of down answers block scratchBase + k
module usiBusFabric (
	usiBusIf.slave  up,
	usiBusIf.master down [usiPkg::usiBlocks]
);
	import usiPkg::*;

	// Per-slot read data after gating
	logic [usiDataWidth-1:0] gatedRd [usiBlocks];
	// Per-slot enable vectors
	logic [usiBlocks-1:0]    slotREd [usiBlocks];
	logic [usiDataWidth-1:0] mergedRd;
	logic [usiBlocks-1:0]    mergedREd;

	// --------------------
	// Downstream links
	// --------------------
	for (genvar k = 0; k < usiBlocks; k++)
	begin : slotGen
		localparam logic [usiBlockWidth-1:0] blockNum = scratchBase + usiBlockWidth'(k);

		assign down[k].wd   = up.wd;
		assign down[k].adrs = up.adrs;
		// Strobe only toward the addressed block
		assign down[k].wEd  = up.wEd && (up.adrs.f.block == blockNum);

		// A slot counts only with its own enable bit
		assign gatedRd[k] = down[k].rEd[k] ? down[k].rd : '0;
		assign slotREd[k] = down[k].rEd;
	end

	// --------------------
	// Read merge
	// --------------------
	always_comb
	begin
		mergedRd  = '0;
		mergedREd = '0;
		for (int k = 0; k < usiBlocks; k++)
		begin
			mergedRd  = mergedRd | gatedRd[k];
			mergedREd = mergedREd | slotREd[k];
		end
	end

	assign up.rd  = mergedRd;
	assign up.rEd = mergedREd;

endmodule

/* hw/usiScratchBlock.sv */
// USI slave with four scratch words and a read-only block number
// Offsets 0x0 to 0xC hold the words, offset 0x10 returns the block number
// Answers with registered rd and its own rEd bit when its block is addressed
// The slot parameter places the block at scratchBase + slot
module usiScratchBlock #(
	parameter int slot = 0
) (
	input  logic    iSCLK,
	input  logic    iSRST,
	usiBusIf.slave  bus
);
	import usiPkg::*;

	localparam logic [usiBlockWidth-1:0] blockNum = scratchBase + usiBlockWidth'(slot);
	// Own bit of the read-enable vector
	localparam logic [usiBlocks-1:0]     ownBit   = usiBlocks'(1) << slot;

	logic [usiDataWidth-1:0] regs [4];
	logic                    hit;
	logic                    wordHit;
	logic [1:0]              wordSel;

	assign hit     = (bus.adrs.f.block == blockNum);
	// Word aligned offsets below 0x10
	assign wordHit = (bus.adrs.f.offset[usiOffWidth-1:4] == '0) &&
	                 (bus.adrs.f.offset[1:0] == 2'b00);
	assign wordSel = bus.adrs.f.offset[3:2];

	// --------------------
	// Write and read
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
			bus.rd  <= '0;
			bus.rEd <= '0;
		end
		else
		begin
			// Fabric already matched the block
			if (bus.wEd && wordHit)
				regs[wordSel] <= bus.wd;
			if (hit)
			begin
				bus.rEd <= ownBit;
				if (wordHit)
					bus.rd <= regs[wordSel];
				else if (bus.adrs.f.offset == scratchOffId)
					bus.rd <= usiDataWidth'(blockNum);
				else
					bus.rd <= '0;
			end
			else
			begin
				// Silent when another block is addressed
				bus.rd  <= '0;
				bus.rEd <= '0;
			end
		end
	end

endmodule

/* hw/usiSubsystemTop.sv */
// Top of the USI control path with plain AXI4-Lite slave ports
// AXI bridge -> master CSR -> fabric -> scratch blocks in slots 0 and 1
module usiSubsystemTop (
	input  logic                            iSCLK,
	input  logic                            iSRST,
	input  logic [usiPkg::usiAdrsWidth-1:0] awaddr,
	input  logic                            awvalid,
	output logic                            awready,
	input  logic [usiPkg::usiDataWidth-1:0] wdata,
	input  logic                            wvalid,
	output logic                            wready,
	output logic [1:0]                      bresp,
	output logic                            bvalid,
	input  logic                            bready,
	input  logic [usiPkg::usiAdrsWidth-1:0] araddr,
	input  logic                            arvalid,
	output logic                            arready,
	output logic [usiPkg::usiDataWidth-1:0] rdata,
	output logic [1:0]                      rresp,
	output logic                            rvalid,
	input  logic                            rready
);
	import usiPkg::*;

	// Manual CSR port
	logic [usiDataWidth-1:0] csrWd;
	usiAdrsT                 csrAdrs;
	logic                    csrWCke;
	logic [usiDataWidth-1:0] csrRd;

	// USI links
	usiBusIf csrBus ();
	usiBusIf blockBus [usiBlocks] ();

	axiLiteCsrBridge bridge (
		.iSCLK   (iSCLK),
		.iSRST   (iSRST),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.wd      (csrWd),
		.adrs    (csrAdrs),
		.wCke    (csrWCke),
		.rd      (csrRd)
	);

	microControllerCsr csr (
		.iSCLK (iSCLK),
		.iSRST (iSRST),
		.wd    (csrWd),
		.adrs  (csrAdrs),
		.wCke  (csrWCke),
		.rd    (csrRd),
		.bus   (csrBus.master)
	);

	usiBusFabric fabric (
		.up   (csrBus.slave),
		.down (blockBus)
	);

	// --------------------
	// Scratch blocks
	// --------------------
	for (genvar k = 0; k < usiBlocks; k++)
	begin : blockGen
		usiScratchBlock #(
			.slot (k)
		) scratch (
			.iSCLK (iSCLK),
			.iSRST (iSRST),
			.bus   (blockBus[k].slave)
		);
	end

endmodule

/* verification/usiSubsystem_asserts.sv */
// Protocol and timing checker for the USI subsystem, bound to its top level
// Reset state of the handshake outputs, response stability, fixed read latency
// and the single-cycle bus write strobe
module usiSubsystemAsserts (
	input logic                            iSCLK,
	input logic                            iSRST,
	input logic                            awready,
	input logic                            wready,
	input logic                            arvalid,
	input logic                            arready,
	input logic                            bvalid,
	input logic                            bready,
	input logic                            rvalid,
	input logic                            rready,
	input logic [usiPkg::usiDataWidth-1:0] rdata,
	input logic                            wEd
);
	timeunit 1ns;
	timeprecision 1ps;
	import usiPkg::*;

	// Failed assertions so far
	int failCount = 0;

	// --------------------
	// Reset and responses
	// --------------------
	resetQuiet: assert property (@(posedge iSCLK)
		iSRST |=> !awready && !wready && !arready && !bvalid && !rvalid)
	else
	begin
		failCount++;
		$error("AXI handshake outputs active during reset");
	end

	// Write response waits for BREADY
	bvalidHold: assert property (@(posedge iSCLK) disable iff (iSRST)
		bvalid && !bready |=> bvalid)
	else
	begin
		failCount++;
		$error("BVALID dropped before BREADY");
	end

	rvalidHold: assert property (@(posedge iSCLK) disable iff (iSRST)
		rvalid && !rready |=> rvalid && $stable(rdata))
	else
	begin
		failCount++;
		$error("RVALID dropped or RDATA changed before RREADY");
	end

	// --------------------
	// Timing
	// --------------------
	readRise: assert property (@(posedge iSCLK) disable iff (iSRST)
		arvalid && arready |-> ##readLatency rvalid)
	else
	begin
		failCount++;
		$error("RVALID missing readLatency cycles after AR handshake");
	end

	// No early RVALID either
	readNotEarly: assert property (@(posedge iSCLK) disable iff (iSRST)
		$rose(rvalid) |-> $past(arvalid && arready, readLatency))
	else
	begin
		failCount++;
		$error("RVALID rose at the wrong distance from AR handshake");
	end

	wEdPulse: assert property (@(posedge iSCLK) disable iff (iSRST)
		wEd |=> !wEd)
	else
	begin
		failCount++;
		$error("bus wEd longer than one cycle");
	end

	// Write response rises with the bus strobe
	bvalidWithWEd: assert property (@(posedge iSCLK) disable iff (iSRST)
		wEd |-> $rose(bvalid))
	else
	begin
		failCount++;
		$error("BVALID did not rise together with wEd");
	end

endmodule

bind usiSubsystemTop usiSubsystemAsserts protocolChk (
	.iSCLK   (iSCLK),
	.iSRST   (iSRST),
	.awready (awready),
	.wready  (wready),
	.arvalid (arvalid),
	.arready (arready),
	.bvalid  (bvalid),
	.bready  (bready),
	.rvalid  (rvalid),
	.rready  (rready),
	.rdata   (rdata),
	.wEd     (csrBus.wEd)
);

/* verification/usiSubsystemTb.sv */
// Testbench for the USI subsystem top level
// Drives AXI4-Lite writes and reads with random ready delays
// Read data is compared with a register model of the scratch blocks and CSR
// Handshake and timing checks come from the bound checker module
module usiSubsystemTb;
	timeunit 1ns;
	timeprecision 1ps;
	import usiPkg::*;

	localparam int timeoutCycles = 64;

	logic                    iSCLK;
	logic                    iSRST;
	logic [usiAdrsWidth-1:0] awaddr;
	logic                    awvalid;
	logic                    awready;
	logic [usiDataWidth-1:0] wdata;
	logic                    wvalid;
	logic                    wready;
	logic [1:0]              bresp;
	logic                    bvalid;
	logic                    bready;
	logic [usiAdrsWidth-1:0] araddr;
	logic                    arvalid;
	logic                    arready;
	logic [usiDataWidth-1:0] rdata;
	logic [1:0]              rresp;
	logic                    rvalid;
	logic                    rready;

	int seed;
	int errorCount;
	int timeoutCount;

	// --------------------
	// Register model
	// --------------------
	logic [usiDataWidth-1:0] scratchModel [usiBlocks][4];
	logic [usiDataWidth-1:0] lastWdModel;
	logic [usiAdrsWidth-1:0] lastAdrsModel;
	logic [usiDataWidth-1:0] wrCountModel;
	logic [usiDataWidth-1:0] busRdModel;
	logic [usiBlocks-1:0]    rEdModel;
	// Result of the last read
	logic [usiDataWidth-1:0] readData;
	logic [1:0]              readResp;

	usiSubsystemTop u_dut (.*);

	initial
	begin
		iSCLK = 1'b0;
		forever
			#50 iSCLK = ~iSCLK;
	end

	function automatic logic [usiAdrsWidth-1:0] makeAdrs(input logic [7:0] block,
		input logic [15:0] offset);
		return {block, offset};
	endfunction

	// Scratch slot of a block, -1 when unmapped
	function automatic int slotOf(input logic [7:0] block);
		if (int'(block) >= int'(scratchBase) && int'(block) < int'(scratchBase) + usiBlocks)
			return int'(block) - int'(scratchBase);
		return -1;
	endfunction

	// Expected read word for an address
	function automatic logic [usiDataWidth-1:0] expectedRead(input logic [usiAdrsWidth-1:0] adrs);
		logic [7:0]  block;
		logic [15:0] offset;
		int          slot;
		block  = adrs[23:16];
		offset = adrs[15:0];
		slot   = slotOf(block);
		if (block == csrBlockId)
		begin
			case (offset)
				csrOffLastWd:   return lastWdModel;
				csrOffLastAdrs: return usiDataWidth'(lastAdrsModel);
				csrOffWrCount:  return wrCountModel;
				csrOffBusRd:    return busRdModel;
				csrOffREd:      return usiDataWidth'(rEdModel);
				default:        return '0;
			endcase
		end
		else if (slot >= 0)
		begin
			if (offset < 16'h0010 && offset[1:0] == 2'b00)
				return scratchModel[slot][offset[3:2]];
			if (offset == 16'h0010)
				return usiDataWidth'(block);
		end
		return '0;
	endfunction

	// CSR capture follows the last scratch address on the bus
	task automatic noteBusCapture(input logic [usiAdrsWidth-1:0] adrs);
		int slot;
		slot = slotOf(adrs[23:16]);
		if (slot >= 0)
		begin
			busRdModel = expectedRead(adrs);
			rEdModel   = usiBlocks'(1) << slot;
		end
	endtask

	task automatic checkValue(input string name, input logic [usiDataWidth-1:0] got,
		input logic [usiDataWidth-1:0] exp);
		if (got !== exp)
		begin
			errorCount++;
			$display("[ERROR] %0t ns %s got 0x%08h expected 0x%08h", $time, name, got, exp);
		end
	endtask

	// --------------------
	// AXI tasks
	// --------------------
	// Called at posedge + 1 ns, returns there; handshakes sampled at negedge
	task automatic axiWrite(input logic [usiAdrsWidth-1:0] adrs,
		input logic [usiDataWidth-1:0] data);
		logic awDone;
		logic wDone;
		logic bDone;
		int   cycles;
		int   delay;
		int   slot;
		if (timeoutCount != 0)
			return;
		awDone  = 1'b0;
		wDone   = 1'b0;
		bDone   = 1'b0;
		cycles  = 0;
		delay   = $random(seed) & 3;
		awaddr  = adrs;
		awvalid = 1'b1;
		wdata   = data;
		wvalid  = 1'b1;
		while (!(awDone && wDone) && cycles < timeoutCycles)
		begin
			@(negedge iSCLK);
			awDone = awDone || awready;
			wDone  = wDone || wready;
			@(posedge iSCLK);
			#1;
			awvalid = !awDone;
			wvalid  = !wDone;
			cycles++;
		end
		cycles = 0;
		// BREADY held back for a random number of cycles
		while (awDone && wDone && !bDone && cycles < timeoutCycles)
		begin
			bready = (cycles >= delay);
			@(negedge iSCLK);
			bDone = bvalid && bready;
			if (bDone)
				checkValue("bresp", usiDataWidth'(bresp), usiDataWidth'(axiRespOkay));
			@(posedge iSCLK);
			#1;
			bready = 1'b0;
			cycles++;
		end
		if (!bDone)
		begin
			timeoutCount++;
			$display("Timeout: write to address 0x%06h got no response", adrs);
			awvalid = 1'b0;
			wvalid  = 1'b0;
		end
		else
		begin
			wrCountModel++;
			lastWdModel   = data;
			lastAdrsModel = adrs;
			slot = slotOf(adrs[23:16]);
			if (slot >= 0 && adrs[15:4] == '0 && adrs[1:0] == 2'b00)
				scratchModel[slot][adrs[3:2]] = data;
			noteBusCapture(adrs);
		end
	endtask

	task automatic axiRead(input logic [usiAdrsWidth-1:0] adrs);
		logic arDone;
		logic rDone;
		int   cycles;
		int   delay;
		arDone  = 1'b0;
		rDone   = 1'b0;
		cycles  = 0;
		delay   = $random(seed) & 7;
		araddr  = adrs;
		arvalid = 1'b1;
		while (!arDone && cycles < timeoutCycles)
		begin
			@(negedge iSCLK);
			arDone = arready;
			@(posedge iSCLK);
			#1;
			arvalid = !arDone;
			cycles++;
		end
		cycles = 0;
		// Delays past readLatency keep RVALID waiting
		while (arDone && !rDone && cycles < timeoutCycles)
		begin
			rready = (cycles >= delay);
			@(negedge iSCLK);
			if (rvalid && rready)
			begin
				rDone    = 1'b1;
				readData = rdata;
				readResp = rresp;
			end
			@(posedge iSCLK);
			#1;
			rready = 1'b0;
			cycles++;
		end
		if (!rDone)
		begin
			timeoutCount++;
			$display("Timeout: read from address 0x%06h got no response", adrs);
			arvalid = 1'b0;
		end
	endtask

	task automatic expectRead(input logic [usiAdrsWidth-1:0] adrs);
		logic [usiDataWidth-1:0] exp;
		if (timeoutCount != 0)
			return;
		exp = expectedRead(adrs);
		axiRead(adrs);
		if (timeoutCount == 0)
		begin
			checkValue($sformatf("rdata[0x%06h]", adrs), readData, exp);
			checkValue("rresp", usiDataWidth'(readResp), usiDataWidth'(axiRespOkay));
			noteBusCapture(adrs);
		end
	endtask

	task automatic readAllScratch();
		for (int k = 0; k < usiBlocks; k++)
			for (int i = 0; i < 4; i++)
				expectRead(makeAdrs(scratchBase + usiBlockWidth'(k), usiOffWidth'(i * 4)));
	endtask

	// --------------------
	// Stimulus
	// --------------------
	initial
	begin
		seed         = 32'hbda9a434;
		errorCount   = 0;
		timeoutCount = 0;
		iSRST   = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		for (int k = 0; k < usiBlocks; k++)
			for (int i = 0; i < 4; i++)
				scratchModel[k][i] = '0;
		lastWdModel   = '0;
		lastAdrsModel = '0;
		wrCountModel  = '0;
		busRdModel    = '0;
		rEdModel      = '0;
		readData      = '0;
		readResp      = '0;
		repeat (4) @(posedge iSCLK);
		#1;
		iSRST = 1'b0;

		// Quiet bus, then all zero, status before scratch
		for (int i = 0; i < 3; i++)
		begin
			@(negedge iSCLK);
			checkValue("bvalid", usiDataWidth'(bvalid), '0);
			checkValue("rvalid", usiDataWidth'(rvalid), '0);
		end
		@(posedge iSCLK);
		#1;
		for (int i = 0; i < 5; i++)
			expectRead(makeAdrs(csrBlockId, usiOffWidth'(i * 4)));
		readAllScratch();

		// Block ids
		for (int k = 0; k < usiBlocks; k++)
			expectRead(makeAdrs(scratchBase + usiBlockWidth'(k), scratchOffId));

		// One block at a time, the other must hold
		for (int k = 0; k < usiBlocks; k++)
		begin
			for (int i = 0; i < 4; i++)
				axiWrite(makeAdrs(scratchBase + usiBlockWidth'(k), usiOffWidth'(i * 4)),
					$random(seed));
			readAllScratch();
		end

		// Write history and bus capture
		for (int i = 0; i < 3; i++)
			axiWrite(makeAdrs(scratchBase + usiBlockWidth'($random(seed) & 1),
				usiOffWidth'(($random(seed) & 3) * 4)), $random(seed));
		expectRead(makeAdrs(csrBlockId, csrOffLastWd));
		expectRead(makeAdrs(csrBlockId, csrOffLastAdrs));
		expectRead(makeAdrs(csrBlockId, csrOffWrCount));
		expectRead(makeAdrs(scratchBase + 8'h01, 16'h0008));
		expectRead(makeAdrs(csrBlockId, csrOffBusRd));
		expectRead(makeAdrs(csrBlockId, csrOffREd));

		// Unmapped blocks
		axiWrite(makeAdrs(8'h07, 16'h0000), $random(seed));
		readAllScratch();
		expectRead(makeAdrs(8'h00, 16'h0000));
		expectRead(makeAdrs(8'h05, 16'h0004));
		expectRead(makeAdrs(8'hFF, 16'h0010));
		expectRead(makeAdrs(csrBlockId, csrOffWrCount));

		// Let pending assertions finish
		repeat (8) @(posedge iSCLK);
		$display("Done: %0d data errors, %0d assertion failures, %0d timeouts",
			errorCount, u_dut.protocolChk.failCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0 && u_dut.protocolChk.failCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* list.f */
hw/usiPkg.sv
hw/usiBusIf.sv
hw/axiLiteCsrBridge.sv
hw/microControllerCsr.sv
hw/usiBusFabric.sv
hw/usiScratchBlock.sv
hw/usiSubsystemTop.sv
verification/usiSubsystem_asserts.sv
verification/usiSubsystemTb.sv

/* run.sh */
#!/bin/sh
# Build the USI subsystem testbench with Verilator and run it
# Exit status is zero only when the simulation output holds the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module usiSubsystemTb -f list.f -o usiSubsystemSim &&
./obj_dir/usiSubsystemSim +verilator+error+limit+1000 | tee /dev/stderr | grep -q -F '>>> PASS' &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
